// ==== src/trace_pkg.sv ====
`default_nettype none

package trace_pkg;

   // trace sample and flit geometry
   localparam int TRACE_WIDTH = 40;
   localparam int FLIT_WIDTH = 16;
   localparam int NUM_PAYLOAD_FLITS = (TRACE_WIDTH + FLIT_WIDTH - 1) / FLIT_WIDTH;

   // sample zero-extended to a whole number of flits
   localparam int PAYLOAD_PAD_WIDTH = NUM_PAYLOAD_FLITS * FLIT_WIDTH;
   localparam int PAYLOAD_CNT_WIDTH = $clog2(NUM_PAYLOAD_FLITS + 1);

   // queue depths
   localparam int CAPTURE_DEPTH = 8;
   localparam int FLIT_QUEUE_DEPTH = 4;

   // saturating drop counter, sent in the low bits of an overflow record
   localparam int DROP_COUNT_WIDTH = 16;

   // flags flit layout: type in 15:14, subtype in 13:10, rest reserved
   localparam logic [1:0] TYPE_EVENT = 2'b10;
   localparam logic [3:0] SUBTYPE_TRACE = 4'h0;
   localparam logic [3:0] SUBTYPE_OVERFLOW = 4'h5;
   localparam int FLAGS_RESERVED_WIDTH = FLIT_WIDTH - 6;

   // one flit of the debug interconnect, valid and ready travel beside it
   typedef struct packed {
      logic [FLIT_WIDTH-1:0] data;
      logic                  last;
   } dii_flit;

   // queued trace entry; overflow records carry the drop count in data
   typedef struct packed {
      logic                   overflow;
      logic [TRACE_WIDTH-1:0] data;
   } trace_record;

endpackage

`default_nettype wire

// ==== src/dii_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// flit stream between the packetizer and the output flit queue
interface dii_if import trace_pkg::*; ();

   logic    valid;
   logic    ready;
   dii_flit flit;

   // producer side, holds flit stable while valid and not ready
   modport source (
      output valid,
      output flit,
      input  ready
   );

   // consumer side
   modport sink (
      input  valid,
      input  flit,
      output ready
   );

endinterface

`default_nettype wire

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
   parameter type entry_t = logic [7:0],
   parameter int  DEPTH = 4
) (
   input  wire         clk,
   input  wire         rst,
   input  wire         push,
   input  wire entry_t push_data,
   input  wire         pop,
   output entry_t      head,
   output logic        empty,
   output logic        full
);

   localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_WIDTH = $clog2(DEPTH + 1);

   entry_t               mem [DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [CNT_WIDTH-1:0] count;
   logic                 do_push;
   logic                 do_pop;

   // a pop on an empty queue is ignored
   assign do_push = push && !full;
   assign do_pop = pop && !empty;

   assign empty = (count == '0);
   assign full = (count == CNT_WIDTH'(DEPTH));

   // show-ahead: the oldest entry is always on the output
   assign head = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (do_push) begin
            // wrap explicitly so any depth works
            if (wr_ptr == PTR_WIDTH'(DEPTH - 1)) begin
               wr_ptr <= '0;
            end else begin
               wr_ptr <= wr_ptr + 1'b1;
            end
         end
         if (do_pop) begin
            if (rd_ptr == PTR_WIDTH'(DEPTH - 1)) begin
               rd_ptr <= '0;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/trace_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module trace_capture import trace_pkg::*; (
   input  wire                   clk,
   input  wire                   rst,
   input  wire [TRACE_WIDTH-1:0] sample_data,
   input  wire                   sample_valid,
   output trace_record           record,
   output logic                  record_valid,
   input  wire                   record_pop
);

   logic                        fifo_empty;
   logic                        fifo_full;
   logic                        push;
   trace_record                 push_data;
   logic                        push_sample;
   logic                        push_overflow;
   logic                        drop_sample;
   logic [DROP_COUNT_WIDTH-1:0] drop_count;
   logic                        drop_saturated;

   // a strobe always wins the slot, so sample order is kept
   assign push_sample = sample_valid && !fifo_full;

   // pending drops get reported in the first quiet cycle with room
   assign push_overflow = !sample_valid && !fifo_full && (drop_count != '0);

   // samples lost because the queue is full
   assign drop_sample = sample_valid && fifo_full;

   assign drop_saturated = (drop_count == '1);

   assign push = push_sample || push_overflow;

   always_comb begin
      push_data.overflow = push_overflow;
      if (push_overflow) begin
         // count goes in the low bits, upper bits are zero
         push_data.data = TRACE_WIDTH'(drop_count);
      end else begin
         push_data.data = sample_data;
      end
   end

   // drop counter saturates instead of wrapping
   always_ff @(posedge clk) begin
      if (rst) begin
         drop_count <= '0;
      end else if (drop_sample) begin
         if (!drop_saturated) begin
            drop_count <= drop_count + 1'b1;
         end
      end else if (push_overflow) begin
         drop_count <= '0;
      end
   end

   sync_fifo #(
      .entry_t (trace_record),
      .DEPTH   (CAPTURE_DEPTH)
   ) record_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (push),
      .push_data (push_data),
      .pop       (record_pop),
      .head      (record),
      .empty     (fifo_empty),
      .full      (fifo_full)
   );

   assign record_valid = !fifo_empty;

endmodule

`default_nettype wire

// ==== src/trace_packetizer.sv ====
`timescale 1ns/1ns
`default_nettype none

module trace_packetizer import trace_pkg::*; (
   input  wire                  clk,
   input  wire                  rst,
   input  wire [FLIT_WIDTH-1:0] id,
   input  wire [FLIT_WIDTH-1:0] event_dest,
   input  wire trace_record     record,
   input  wire                  record_valid,
   output logic                 record_pop,
   dii_if.source                flits
);

   typedef enum logic [2:0] {
      IDLE,
      DESTINATION,
      SOURCE,
      FLAGS,
      OVERFLOW,
      PAYLOAD
   } state_t;

   state_t                       state;
   state_t                       next_state;
   logic [PAYLOAD_CNT_WIDTH-1:0] flit_cnt;
   logic [PAYLOAD_CNT_WIDTH-1:0] next_flit_cnt;
   logic [PAYLOAD_PAD_WIDTH-1:0] padded_data;
   logic [3:0]                   subtype;
   logic                         last_payload;
   logic                         out_valid;
   dii_flit                      out_flit;

   // zero-extend so the final payload flit reads zeros above the sample
   assign padded_data = PAYLOAD_PAD_WIDTH'(record.data);

   assign subtype = record.overflow ? SUBTYPE_OVERFLOW : SUBTYPE_TRACE;

   assign last_payload = (flit_cnt == PAYLOAD_CNT_WIDTH'(NUM_PAYLOAD_FLITS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         flit_cnt <= '0;
      end else begin
         state <= next_state;
         flit_cnt <= next_flit_cnt;
      end
   end

   always_comb begin
      next_state = state;
      next_flit_cnt = flit_cnt;
      record_pop = 1'b0;
      out_valid = 1'b0;
      out_flit.data = '0;
      out_flit.last = 1'b0;

      case (state)
         IDLE: begin
            // header starts the cycle after a record shows up
            if (record_valid) begin
               next_state = DESTINATION;
            end
         end
         DESTINATION: begin
            out_valid = 1'b1;
            out_flit.data = event_dest;
            if (flits.ready) begin
               next_state = SOURCE;
            end
         end
         SOURCE: begin
            out_valid = 1'b1;
            out_flit.data = id;
            if (flits.ready) begin
               next_state = FLAGS;
            end
         end
         FLAGS: begin
            out_valid = 1'b1;
            out_flit.data = {TYPE_EVENT, subtype, {FLAGS_RESERVED_WIDTH{1'b0}}};
            if (flits.ready) begin
               next_flit_cnt = '0;
               next_state = record.overflow ? OVERFLOW : PAYLOAD;
            end
         end
         OVERFLOW: begin
            // single flit with the drop count
            out_valid = 1'b1;
            out_flit.data = record.data[FLIT_WIDTH-1:0];
            out_flit.last = 1'b1;
            if (flits.ready) begin
               record_pop = 1'b1;
               next_state = IDLE;
            end
         end
         PAYLOAD: begin
            // lowest bits go out first
            out_valid = 1'b1;
            out_flit.data = padded_data[flit_cnt*FLIT_WIDTH +: FLIT_WIDTH];
            out_flit.last = last_payload;
            if (flits.ready) begin
               if (last_payload) begin
                  record_pop = 1'b1;
                  next_state = IDLE;
               end else begin
                  next_flit_cnt = flit_cnt + 1'b1;
               end
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   assign flits.valid = out_valid;
   assign flits.flit = out_flit;

endmodule

`default_nettype wire

// ==== src/debug_trace_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_trace_unit import trace_pkg::*; (
   input  wire                   clk,
   input  wire                   rst,
   input  wire [FLIT_WIDTH-1:0]  id,
   input  wire [FLIT_WIDTH-1:0]  event_dest,
   input  wire [TRACE_WIDTH-1:0] sample_data,
   input  wire                   sample_valid,
   output logic [FLIT_WIDTH-1:0] debug_data,
   output logic                  debug_last,
   output logic                  debug_valid,
   input  wire                   debug_ready
);

   trace_record record;
   logic        record_valid;
   logic        record_pop;
   logic        flit_push;
   logic        out_pop;
   dii_flit     out_head;
   logic        out_empty;
   logic        out_full;

   dii_if flit_link ();

   trace_capture capture (
      .clk          (clk),
      .rst          (rst),
      .sample_data  (sample_data),
      .sample_valid (sample_valid),
      .record       (record),
      .record_valid (record_valid),
      .record_pop   (record_pop)
   );

   trace_packetizer packetizer (
      .clk          (clk),
      .rst          (rst),
      .id           (id),
      .event_dest   (event_dest),
      .record       (record),
      .record_valid (record_valid),
      .record_pop   (record_pop),
      .flits        (flit_link.source)
   );

   // flit queue takes a flit on every handshake with the packetizer
   assign flit_link.ready = !out_full;
   assign flit_push = flit_link.valid && flit_link.ready;
   assign out_pop = debug_valid && debug_ready;

   sync_fifo #(
      .entry_t (dii_flit),
      .DEPTH   (FLIT_QUEUE_DEPTH)
   ) flit_queue (
      .clk       (clk),
      .rst       (rst),
      .push      (flit_push),
      .push_data (flit_link.flit),
      .pop       (out_pop),
      .head      (out_head),
      .empty     (out_empty),
      .full      (out_full)
   );

   assign debug_valid = !out_empty;
   assign debug_data = out_head.data;
   assign debug_last = out_head.last;

endmodule

`default_nettype wire

// ==== testbench/debug_trace_unit_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module debug_trace_unit_sva import trace_pkg::*; (
   input wire                  clk,
   input wire                  rst,
   input wire [FLIT_WIDTH-1:0] debug_data,
   input wire                  debug_last,
   input wire                  debug_valid,
   input wire                  debug_ready
);

   // position of the current flit inside its packet
   logic [2:0] flit_idx;

   always_ff @(posedge clk) begin
      if (rst) begin
         flit_idx <= '0;
      end else if (debug_valid && debug_ready) begin
         if (debug_last) begin
            flit_idx <= '0;
         end else begin
            flit_idx <= flit_idx + 1'b1;
         end
      end
   end

   valid_low_after_reset: assert property (@(posedge clk) rst |=> !debug_valid)
      else $error("debug_valid high during reset or in the cycle after it");

   stable_while_stalled: assert property (@(posedge clk) disable iff (rst)
      debug_valid && !debug_ready |=>
         debug_valid && $stable(debug_data) && $stable(debug_last))
      else $error("output flit changed while stalled");

   flags_third: assert property (@(posedge clk) disable iff (rst)
      debug_valid && flit_idx == 3'd2 |->
         debug_data[15:14] == TYPE_EVENT && debug_data[9:0] == '0 && !debug_last)
      else $error("third flit of a packet is not a flags flit");

endmodule

bind debug_trace_unit debug_trace_unit_sva protocol_checks (
   .clk         (clk),
   .rst         (rst),
   .debug_data  (debug_data),
   .debug_last  (debug_last),
   .debug_valid (debug_valid),
   .debug_ready (debug_ready)
);

`default_nettype wire

// ==== testbench/tb_debug_trace_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_debug_trace_unit import trace_pkg::*; ();

   localparam int PKT_FLITS = 3 + NUM_PAYLOAD_FLITS;
   localparam int DRAIN_TIMEOUT = 2000;

   logic                   clk = 1'b0;
   logic                   rst;
   logic [FLIT_WIDTH-1:0]  id;
   logic [FLIT_WIDTH-1:0]  event_dest;
   logic [TRACE_WIDTH-1:0] sample_data;
   logic                   sample_valid;
   logic [FLIT_WIDTH-1:0]  debug_data;
   logic                   debug_last;
   logic                   debug_valid;
   logic                   debug_ready;

   integer                 seed = 7;
   logic [TRACE_WIDTH-1:0] model [$];
   logic [FLIT_WIDTH-1:0]  pkt [0:7];
   int                     pkt_len = 0;
   int                     sent_count = 0;
   int                     delivered_count = 0;
   int                     drops_total = 0;
   int                     overflow_pkts = 0;
   int                     overflow_before = 0;
   int                     pending_skip = 0;
   logic [FLIT_WIDTH-1:0]  exp_id;
   logic [FLIT_WIDTH-1:0]  exp_dest;

   debug_trace_unit uut (
      .clk          (clk),
      .rst          (rst),
      .id           (id),
      .event_dest   (event_dest),
      .sample_data  (sample_data),
      .sample_valid (sample_valid),
      .debug_data   (debug_data),
      .debug_last   (debug_last),
      .debug_valid  (debug_valid),
      .debug_ready  (debug_ready)
   );

   always #5 clk = ~clk;

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         stop_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                                     name, got, exp));
      end
   endtask

   // compare one finished packet against the sample model
   task automatic check_packet();
      logic [FLIT_WIDTH-1:0]                   flags_exp;
      logic [NUM_PAYLOAD_FLITS*FLIT_WIDTH-1:0] exp_padded;
      logic [NUM_PAYLOAD_FLITS*FLIT_WIDTH-1:0] got_padded;
      int                                      n;
      int                                      skip;
      if (pkt_len < 4) begin
         stop_with_failure("a packet ended before its first payload flit");
      end else begin
         check_value("debug_data destination", pkt[0], exp_dest);
         check_value("debug_data source id", pkt[1], exp_id);
         if (pkt[2][13:10] == SUBTYPE_OVERFLOW) begin
            flags_exp = {TYPE_EVENT, SUBTYPE_OVERFLOW, 10'b0};
            check_value("debug_data overflow flags", pkt[2], flags_exp);
            check_value("overflow packet length", pkt_len, 4);
            n = pkt[3];
            if (n == 0 || n < pending_skip || n - pending_skip > model.size()) begin
               stop_with_failure("overflow count does not match the outstanding samples");
            end else begin
               // drops already passed over by earlier trace packets count first
               repeat (n - pending_skip) void'(model.pop_front());
               pending_skip = 0;
               drops_total += n;
               overflow_pkts++;
            end
         end else begin
            flags_exp = {TYPE_EVENT, SUBTYPE_TRACE, 10'b0};
            check_value("debug_data trace flags", pkt[2], flags_exp);
            check_value("trace packet length", pkt_len, PKT_FLITS);
            if (model.size() == 0) begin
               stop_with_failure("a trace packet arrived with no sample outstanding");
            end else begin
               for (int k = 0; k < NUM_PAYLOAD_FLITS; k++) begin
                  got_padded[k*FLIT_WIDTH +: FLIT_WIDTH] = pkt[3 + k];
               end
               // a sample that takes a freed slot goes ahead of the pending
               // overflow record, so the dropped ones before it are passed over
               skip = 0;
               while (skip < model.size() && model[skip] !== got_padded[TRACE_WIDTH-1:0]) begin
                  skip++;
               end
               if (skip == model.size()) begin
                  skip = 0;
               end
               // zero-extended, lowest flit first
               exp_padded = model[skip];
               for (int k = 0; k < NUM_PAYLOAD_FLITS; k++) begin
                  check_value($sformatf("debug_data payload flit %0d", k), pkt[3 + k],
                              exp_padded[k*FLIT_WIDTH +: FLIT_WIDTH]);
               end
               repeat (skip) void'(model.pop_front());
               void'(model.pop_front());
               pending_skip += skip;
               delivered_count++;
            end
         end
      end
   endtask

   // packet collector on the output port
   always @(posedge clk) begin
      if (!rst && debug_valid && debug_ready) begin
         if (pkt_len >= PKT_FLITS) begin
            stop_with_failure("a packet ran past its length without a last flag");
         end else begin
            pkt[pkt_len] = debug_data;
            pkt_len = pkt_len + 1;
            if (debug_last) begin
               check_packet();
               pkt_len = 0;
            end
         end
      end
   end

   task automatic run_phase(input int cycles, input bit stall_mode);
      int                     burst_left;
      int                     low_left;
      logic                   strobe;
      logic                   ready_now;
      logic [63:0]            raw;
      logic [TRACE_WIDTH-1:0] value;
      burst_left = 0;
      low_left = 0;
      for (int i = 0; i < cycles; i++) begin
         @(posedge clk);
         // single strobes mixed with back-to-back bursts
         if (burst_left > 0) begin
            strobe = 1'b1;
            burst_left--;
         end else if (($random(seed) & 7) == 0) begin
            strobe = 1'b1;
            burst_left = $random(seed) & 7;
         end else begin
            strobe = (($random(seed) & 3) == 0);
         end
         raw = {$random(seed), $random(seed)};
         value = raw[TRACE_WIDTH-1:0];
         // long ready-low stretches fill both queues
         if (low_left > 0) begin
            ready_now = 1'b0;
            low_left--;
         end else if (stall_mode && (($random(seed) & 15) == 0)) begin
            ready_now = 1'b0;
            low_left = 50 + ($random(seed) & 31);
         end else begin
            ready_now = (($random(seed) & 3) != 0);
         end
         sample_valid <= strobe;
         sample_data <= value;
         debug_ready <= ready_now;
         if (strobe) begin
            model.push_back(value);
            sent_count++;
         end
      end
   endtask

   task automatic drain();
      int waited;
      @(posedge clk);
      sample_valid <= 1'b0;
      debug_ready <= 1'b1;
      waited = 0;
      while (model.size() != 0 || pending_skip != 0 || debug_valid || pkt_len != 0) begin
         if (waited >= DRAIN_TIMEOUT) begin
            stop_with_failure("timeout while waiting for outstanding packets to drain");
         end
         @(posedge clk);
         waited++;
      end
   endtask

   // only called while the unit is idle
   task automatic set_ids(input logic [FLIT_WIDTH-1:0] new_id,
                          input logic [FLIT_WIDTH-1:0] new_dest);
      @(posedge clk);
      id <= new_id;
      event_dest <= new_dest;
      exp_id = new_id;
      exp_dest = new_dest;
      @(posedge clk);
   endtask

   initial begin
      rst = 1'b1;
      id = 16'h0011;
      event_dest = 16'h0a0b;
      exp_id = 16'h0011;
      exp_dest = 16'h0a0b;
      sample_data = '0;
      sample_valid = 1'b0;
      debug_ready = 1'b0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // nothing may come out before the first strobe
      repeat (5) begin
         @(posedge clk);
         check_value("debug_valid", debug_valid, 0);
      end

      run_phase(400, 1'b0);
      drain();

      set_ids(16'h2c01, 16'h7f10);
      overflow_before = overflow_pkts;
      run_phase(600, 1'b1);
      drain();
      check_value("overflow packets seen", overflow_pkts > overflow_before, 1);

      set_ids(16'h0305, 16'hbeef);
      run_phase(400, 1'b0);
      drain();

      check_value("delivered plus dropped", delivered_count + drops_total, sent_count);
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
src/trace_pkg.sv
src/dii_if.sv
src/sync_fifo.sv
src/trace_capture.sv
src/trace_packetizer.sv
src/debug_trace_unit.sv
testbench/debug_trace_unit_sva.sv
testbench/tb_debug_trace_unit.sv

// ==== Bender.yml ====
package:
  name: debug_trace_unit

sources:
  # design, in compile order
  - src/trace_pkg.sv
  - src/dii_if.sv
  - src/sync_fifo.sv
  - src/trace_capture.sv
  - src/trace_packetizer.sv
  - src/debug_trace_unit.sv

  # verification
  - target: test
    files:
      - testbench/debug_trace_unit_sva.sv
      - testbench/tb_debug_trace_unit.sv
